// File: src/glb_pkg.sv
// Shared sizes, register map and packed types for the buffer tiles and their testbench
`default_nettype none

package glb_pkg;

    // Chain size
    localparam int NUM_TILES = 4;
    localparam int TILE_ID_WIDTH = 2;

    // Stream word and config data width
    localparam int DATA_WIDTH = 16;

    // One bank is 256 words
    localparam int BANK_ADDR_WIDTH = 8;
    localparam int BANK_WORDS = 1 << BANK_ADDR_WIDTH;

    // Register address inside a tile
    localparam int REG_ADDR_WIDTH = 3;

    // Register map
    // Bit 0 enables the engine
    localparam logic [REG_ADDR_WIDTH-1:0] REG_STORE_ON   = 3'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_STORE_ADDR = 3'd1;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_STORE_NUM  = 3'd2;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_LOAD_ON    = 3'd3;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_LOAD_ADDR  = 3'd4;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_LOAD_NUM   = 3'd5;

    // One config write, relayed east tile by tile
    typedef struct packed {
        logic                      wr_en;
        logic [TILE_ID_WIDTH-1:0]  tile_id;
        logic [REG_ADDR_WIDTH-1:0] reg_addr;
        logic [DATA_WIDTH-1:0]     data;
    } cfg_req_t;

    // DMA region
    // Extra count bit so a whole bank fits
    typedef struct packed {
        logic [BANK_ADDR_WIDTH-1:0] start_addr;
        logic [BANK_ADDR_WIDTH:0]   num_words;
    } dma_header_t;

    // Register contents seen by the core
    typedef struct packed {
        logic        store_on;
        dma_header_t store_header;
        logic        load_on;
        dma_header_t load_header;
    } tile_cfg_t;

    // One stream beat, no back-pressure
    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] data;
    } strm_word_t;

endpackage

`default_nettype wire

// File: src/glb_tile_cfg.sv
// Per-tile register block; decodes relayed config writes for this tile and passes them east
`default_nettype none
`timescale 1ns/1ps

module glb_tile_cfg #(
    parameter int TILE_ID = 0
) (
    input  wire logic              clk,
    input  wire logic              reset,

    // Config relay
    input  wire glb_pkg::cfg_req_t cfg_wst,
    output glb_pkg::cfg_req_t      cfg_est,

    // To the core
    output glb_pkg::tile_cfg_t     tile_cfg
);

    // Own index in tile_id width
    localparam logic [glb_pkg::TILE_ID_WIDTH-1:0] TILE_SEL =
        TILE_ID[glb_pkg::TILE_ID_WIDTH-1:0];

    glb_pkg::tile_cfg_t                   cfg_q;
    logic                                 wr_hit;
    logic [glb_pkg::BANK_ADDR_WIDTH-1:0]  wr_addr_field;
    logic [glb_pkg::BANK_ADDR_WIDTH:0]    wr_num_field;

    // Write addressed to this tile
    assign wr_hit = cfg_wst.wr_en && (cfg_wst.tile_id == TILE_SEL);

    // Low bits of the data word
    assign wr_addr_field = cfg_wst.data[glb_pkg::BANK_ADDR_WIDTH-1:0];
    assign wr_num_field  = cfg_wst.data[glb_pkg::BANK_ADDR_WIDTH:0];

    // One register stage per tile on the relay
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_est <= '0;
        end else begin
            cfg_est <= cfg_wst;
        end
    end

    // Register decode
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_q <= '0;
        end else if (wr_hit) begin
            case (cfg_wst.reg_addr)
                glb_pkg::REG_STORE_ON:   cfg_q.store_on <= cfg_wst.data[0];
                glb_pkg::REG_STORE_ADDR: cfg_q.store_header.start_addr <= wr_addr_field;
                glb_pkg::REG_STORE_NUM:  cfg_q.store_header.num_words <= wr_num_field;
                glb_pkg::REG_LOAD_ON:    cfg_q.load_on <= cfg_wst.data[0];
                glb_pkg::REG_LOAD_ADDR:  cfg_q.load_header.start_addr <= wr_addr_field;
                glb_pkg::REG_LOAD_NUM:   cfg_q.load_header.num_words <= wr_num_field;
                // Addresses 6 and 7 are unused
                default: ;
            endcase
        end
    end

    // Straight from the registers
    assign tile_cfg = cfg_q;

    // Regions longer than the bank would alias onto themselves
    a_store_num_in_bank: assert property (@(posedge clk) disable iff (reset)
        cfg_q.store_header.num_words <= glb_pkg::BANK_WORDS);

    a_load_num_in_bank: assert property (@(posedge clk) disable iff (reset)
        cfg_q.load_header.num_words <= glb_pkg::BANK_WORDS);

endmodule

`default_nettype wire

// File: src/glb_core.sv
// SRAM bank of one tile with its store and load DMA engines, instantiated inside each tile
`default_nettype none
`timescale 1ns/1ps

module glb_core (
    input  wire logic               clk,
    input  wire logic               reset,

    input  wire glb_pkg::tile_cfg_t tile_cfg,

    // Streams
    input  wire glb_pkg::strm_word_t strm_f2g,
    output glb_pkg::strm_word_t      strm_g2f,

    // Load start for this tile
    input  wire logic               start_pulse,

    // Done pulses
    output logic                    store_done_pulse,
    output logic                    load_done_pulse
);

    // Bank storage
    logic [glb_pkg::DATA_WIDTH-1:0]      mem [glb_pkg::BANK_WORDS];

    // Store side
    logic [glb_pkg::BANK_ADDR_WIDTH:0]   store_cnt;
    logic [glb_pkg::BANK_ADDR_WIDTH:0]   store_cnt_nxt;
    logic [glb_pkg::BANK_ADDR_WIDTH-1:0] store_addr;
    logic                                store_en;
    logic                                store_last;

    // Load side
    logic                                load_active;
    logic [glb_pkg::BANK_ADDR_WIDTH:0]   load_cnt;
    logic [glb_pkg::BANK_ADDR_WIDTH:0]   load_cnt_nxt;
    logic [glb_pkg::BANK_ADDR_WIDTH-1:0] load_addr;
    logic                                load_start;
    logic                                load_issue_last;

    // Read pipeline with the SRAM read in stage 1 and the output in stage 2
    logic                                rd_valid;
    logic                                rd_last;
    logic [glb_pkg::DATA_WIDTH-1:0]      rd_data;
    logic                                out_valid;
    logic                                out_last;
    logic [glb_pkg::DATA_WIDTH-1:0]      out_data;

    // Beats dropped when disabled or region empty
    assign store_en = strm_f2g.valid && tile_cfg.store_on &&
                      (tile_cfg.store_header.num_words != '0);
    assign store_cnt_nxt = store_cnt + 1'b1;
    assign store_last = (store_cnt_nxt == tile_cfg.store_header.num_words);
    // 8-bit sum wraps at the bank end
    assign store_addr = tile_cfg.store_header.start_addr +
                        store_cnt[glb_pkg::BANK_ADDR_WIDTH-1:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            store_cnt <= '0;
            store_done_pulse <= 1'b0;
        end else begin
            // Done one cycle after the final beat
            store_done_pulse <= store_en && store_last;
            if (store_en) begin
                store_cnt <= store_last ? '0 : store_cnt_nxt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_en) begin
            mem[store_addr] <= strm_f2g.data;
        end
    end

    // Starts ignored while busy or disabled
    assign load_start = start_pulse && tile_cfg.load_on && !load_active &&
                        (tile_cfg.load_header.num_words != '0);
    assign load_cnt_nxt = load_cnt + 1'b1;
    assign load_issue_last = load_active && (load_cnt_nxt == tile_cfg.load_header.num_words);
    assign load_addr = tile_cfg.load_header.start_addr +
                       load_cnt[glb_pkg::BANK_ADDR_WIDTH-1:0];

    // One address issued per active cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            load_active <= 1'b0;
            load_cnt <= '0;
        end else if (load_start) begin
            load_active <= 1'b1;
            load_cnt <= '0;
        end else if (load_active) begin
            if (load_issue_last) begin
                load_active <= 1'b0;
                load_cnt <= '0;
            end else begin
                load_cnt <= load_cnt_nxt;
            end
        end
    end

    // Valid and last shift along with the data
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_valid <= 1'b0;
            rd_last <= 1'b0;
            out_valid <= 1'b0;
            out_last <= 1'b0;
            load_done_pulse <= 1'b0;
        end else begin
            rd_valid <= load_active;
            rd_last <= load_issue_last;
            out_valid <= rd_valid;
            out_last <= rd_last;
            // Cycle after the last beat
            load_done_pulse <= out_last;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[load_addr];
        out_data <= rd_data;
    end

    assign strm_g2f.valid = out_valid;
    assign strm_g2f.data = out_data;

    // Back-to-back only for 1-word regions
    a_store_done_single: assert property (@(posedge clk) disable iff (reset)
        store_done_pulse && (tile_cfg.store_header.num_words > 1) |=> !store_done_pulse);

    a_load_done_single: assert property (@(posedge clk) disable iff (reset)
        load_done_pulse |=> !load_done_pulse);

    // Pipe has drained and no new load is streaming once done is raised
    a_g2f_idle: assert property (@(posedge clk) disable iff (reset)
        load_done_pulse |-> !strm_g2f.valid);

endmodule

`default_nettype wire

// File: src/glb_tile.sv
// One buffer tile; register block plus core, with start relay east and interrupt relay west
`default_nettype none
`timescale 1ns/1ps

module glb_tile #(
    parameter int TILE_ID = 0
) (
    input  wire logic                            clk,
    input  wire logic                            reset,

    // Config relay
    input  wire glb_pkg::cfg_req_t               cfg_wst,
    output glb_pkg::cfg_req_t                    cfg_est,

    // Streams of this tile
    input  wire glb_pkg::strm_word_t             strm_f2g,
    output glb_pkg::strm_word_t                  strm_g2f,

    // Load start vector, eastward
    input  wire logic [glb_pkg::NUM_TILES-1:0]   start_pulse_wst,
    output logic [glb_pkg::NUM_TILES-1:0]        start_pulse_est,

    // Interrupt vector, westward
    input  wire logic [2*glb_pkg::NUM_TILES-1:0] interrupt_est,
    output logic [2*glb_pkg::NUM_TILES-1:0]      interrupt_wst
);

    glb_pkg::tile_cfg_t               tile_cfg;
    logic                             store_done_pulse;
    logic                             load_done_pulse;
    logic [2*glb_pkg::NUM_TILES-1:0]  interrupt_next;

    glb_tile_cfg #(
        .TILE_ID (TILE_ID)
    ) u_glb_tile_cfg (
        .clk      (clk),
        .reset    (reset),
        .cfg_wst  (cfg_wst),
        .cfg_est  (cfg_est),
        .tile_cfg (tile_cfg)
    );

    // Core sees only its own start bit
    glb_core u_glb_core (
        .clk              (clk),
        .reset            (reset),
        .tile_cfg         (tile_cfg),
        .strm_f2g         (strm_f2g),
        .strm_g2f         (strm_g2f),
        .start_pulse      (start_pulse_wst[TILE_ID]),
        .store_done_pulse (store_done_pulse),
        .load_done_pulse  (load_done_pulse)
    );

    // Start vector relay
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start_pulse_est <= '0;
        end else begin
            start_pulse_est <= start_pulse_wst;
        end
    end

    // Own bits replaced by local done pulses
    // Store done in the low half, load done in the high half
    always_comb begin
        interrupt_next = interrupt_est;
        interrupt_next[TILE_ID] = store_done_pulse;
        interrupt_next[glb_pkg::NUM_TILES + TILE_ID] = load_done_pulse;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            interrupt_wst <= '0;
        end else begin
            interrupt_wst <= interrupt_next;
        end
    end

endmodule

`default_nettype wire

// File: src/glb_top.sv
// Top of the buffer; chains NUM_TILES tiles and exposes config, stream, start and interrupt
`default_nettype none
`timescale 1ns/1ps

module glb_top (
    input  wire logic                          clk,
    input  wire logic                          reset,

    // Config writes enter at the west end
    input  wire glb_pkg::cfg_req_t             cfg,

    // Per-tile streams
    input  wire glb_pkg::strm_word_t           strm_f2g [glb_pkg::NUM_TILES],
    output glb_pkg::strm_word_t                strm_g2f [glb_pkg::NUM_TILES],

    // Bit i starts the load of tile i
    input  wire logic [glb_pkg::NUM_TILES-1:0] strm_start_pulse,

    // Store done low half, load done high half
    output logic [2*glb_pkg::NUM_TILES-1:0]    interrupt_pulse
);

    // Chain links, element i feeds tile i from the west
    glb_pkg::cfg_req_t               cfg_chain [glb_pkg::NUM_TILES+1];
    logic [glb_pkg::NUM_TILES-1:0]   start_chain [glb_pkg::NUM_TILES+1];
    // Element i leaves tile i westward
    logic [2*glb_pkg::NUM_TILES-1:0] int_chain [glb_pkg::NUM_TILES+1];

    assign cfg_chain[0] = cfg;
    assign start_chain[0] = strm_start_pulse;
    // Nothing east of the last tile
    assign int_chain[glb_pkg::NUM_TILES] = '0;
    assign interrupt_pulse = int_chain[0];

    for (genvar i = 0; i < glb_pkg::NUM_TILES; i++) begin : g_tile
        glb_tile #(
            .TILE_ID (i)
        ) u_glb_tile (
            .clk             (clk),
            .reset           (reset),
            .cfg_wst         (cfg_chain[i]),
            .cfg_est         (cfg_chain[i+1]),
            .strm_f2g        (strm_f2g[i]),
            .strm_g2f        (strm_g2f[i]),
            .start_pulse_wst (start_chain[i]),
            .start_pulse_est (start_chain[i+1]),
            .interrupt_est   (int_chain[i+1]),
            .interrupt_wst   (int_chain[i])
        );
    end

endmodule

`default_nettype wire

// File: verification/glb_tb.sv
// Simulation top that drives the tile chain and checks loads and interrupts against a bank model
`default_nettype none
`timescale 1ns/1ps

module glb_tb;

    // Run limit in cycles for all tests together
    localparam int MAX_CYCLES = 20000;

    logic                            clk;
    logic                            reset;
    glb_pkg::cfg_req_t               cfg;
    glb_pkg::strm_word_t             strm_f2g [glb_pkg::NUM_TILES];
    glb_pkg::strm_word_t             strm_g2f [glb_pkg::NUM_TILES];
    logic [glb_pkg::NUM_TILES-1:0]   strm_start_pulse;
    logic [2*glb_pkg::NUM_TILES-1:0] interrupt_pulse;

    // Bank model and shadow registers
    logic [glb_pkg::DATA_WIDTH-1:0] shadow [glb_pkg::NUM_TILES][glb_pkg::BANK_WORDS];
    glb_pkg::tile_cfg_t             model_cfg [glb_pkg::NUM_TILES];
    int                             store_beats [glb_pkg::NUM_TILES];
    int                             busy_end [glb_pkg::NUM_TILES];
    logic [glb_pkg::DATA_WIDTH-1:0] exp_q [glb_pkg::NUM_TILES][$];
    int                             int_exp [2*glb_pkg::NUM_TILES];
    int                             int_seen [2*glb_pkg::NUM_TILES];

    int                             strm_len [glb_pkg::NUM_TILES];
    int                             region_addr [glb_pkg::NUM_TILES];
    int                             region_num [glb_pkg::NUM_TILES];
    int                             cyc = 0;
    int                             data_errors = 0;
    int                             int_errors = 0;
    int                             other_errors = 0;
    logic [glb_pkg::DATA_WIDTH-1:0] exp_data;

    glb_top u_glb_top (
        .clk              (clk),
        .reset            (reset),
        .cfg              (cfg),
        .strm_f2g         (strm_f2g),
        .strm_g2f         (strm_g2f),
        .strm_start_pulse (strm_start_pulse),
        .interrupt_pulse  (interrupt_pulse)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Cycle count and run limit
    always @(posedge clk) begin
        cyc++;
        if (cyc >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, loads or interrupts never completed", cyc);
            $display("Testbench failed");
            $finish;
        end
    end

    // Compare process sampling registered outputs at the edge
    always @(posedge clk) begin
        if (!reset) begin
            for (int t = 0; t < glb_pkg::NUM_TILES; t++) begin
                if (strm_g2f[t].valid) begin
                    if (exp_q[t].size() == 0) begin
                        $display("Tile %0d sent a load beat that no start asked for", t);
                        other_errors++;
                    end else begin
                        exp_data = exp_q[t].pop_front();
                        if (strm_g2f[t].data !== exp_data) begin
                            $display("** Error strm_g2f[%0d].data: expected 0x%h, got 0x%h",
                                     t, exp_data, strm_g2f[t].data);
                            data_errors++;
                        end
                    end
                end
            end
            for (int b = 0; b < 2*glb_pkg::NUM_TILES; b++) begin
                if (interrupt_pulse[b]) begin
                    int_seen[b]++;
                    // Expected count is raised when the stimulus is driven
                    if (int_seen[b] > int_exp[b]) begin
                        $display("** Error interrupt_pulse[%0d] count: expected 0x%h, got 0x%h",
                                 b, int_exp[b], int_seen[b]);
                        int_errors++;
                    end
                end
            end
        end
    end

    // Reference contents of one bank word
    function automatic logic [glb_pkg::DATA_WIDTH-1:0] expected_word(input int t, input int addr);
        return shadow[t][addr % glb_pkg::BANK_WORDS];
    endfunction

    // Store rule for one beat
    function automatic void record_store(input int t,
                                         input logic [glb_pkg::DATA_WIDTH-1:0] word);
        int a;
        if (model_cfg[t].store_on) begin
            a = int'(model_cfg[t].store_header.start_addr) + store_beats[t];
            shadow[t][a % glb_pkg::BANK_WORDS] = word;
            store_beats[t]++;
            // Full region written, next stream starts over
            if (store_beats[t] == int'(model_cfg[t].store_header.num_words)) begin
                store_beats[t] = 0;
                int_exp[t]++;
            end
        end
    endfunction

    // Start rule with bit t reaching tile t after t cycles
    function automatic void queue_load(input int t);
        int arrive;
        int num;
        int base;
        arrive = cyc + t;
        num = int'(model_cfg[t].load_header.num_words);
        base = int'(model_cfg[t].load_header.start_addr);
        if (model_cfg[t].load_on && arrive >= busy_end[t]) begin
            for (int k = 0; k < num; k++) begin
                exp_q[t].push_back(expected_word(t, base + k));
            end
            int_exp[glb_pkg::NUM_TILES + t]++;
            // One address per cycle, idle again the cycle after the last
            busy_end[t] = arrive + num + 1;
        end
    endfunction

    function automatic bit all_done();
        bit done;
        done = 1'b1;
        for (int t = 0; t < glb_pkg::NUM_TILES; t++) begin
            if (exp_q[t].size() != 0) done = 1'b0;
        end
        for (int b = 0; b < 2*glb_pkg::NUM_TILES; b++) begin
            if (int_seen[b] < int_exp[b]) done = 1'b0;
        end
        return done;
    endfunction

    function automatic logic [glb_pkg::NUM_TILES-1:0] tile_mask(input int t);
        logic [glb_pkg::NUM_TILES-1:0] m;
        m = '0;
        m[t] = 1'b1;
        return m;
    endfunction

    // Inputs change 1 ns after the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input int t, input logic [glb_pkg::REG_ADDR_WIDTH-1:0] addr,
                             input logic [glb_pkg::DATA_WIDTH-1:0] data);
        cfg.wr_en = 1'b1;
        cfg.tile_id = t[glb_pkg::TILE_ID_WIDTH-1:0];
        cfg.reg_addr = addr;
        cfg.data = data;
        case (addr)
            glb_pkg::REG_STORE_ON:   model_cfg[t].store_on = data[0];
            glb_pkg::REG_STORE_ADDR: model_cfg[t].store_header.start_addr = data[7:0];
            glb_pkg::REG_STORE_NUM:  model_cfg[t].store_header.num_words = data[8:0];
            glb_pkg::REG_LOAD_ON:    model_cfg[t].load_on = data[0];
            glb_pkg::REG_LOAD_ADDR:  model_cfg[t].load_header.start_addr = data[7:0];
            glb_pkg::REG_LOAD_NUM:   model_cfg[t].load_header.num_words = data[8:0];
            default: ;
        endcase
        step();
        cfg = '0;
        // Let the write ripple to the last tile
        repeat (glb_pkg::NUM_TILES) step();
    endtask

    // Address and count sit right above the enable register
    task automatic set_region(input int t, input logic [glb_pkg::REG_ADDR_WIDTH-1:0] on_reg,
                              input int addr, input int num);
        write_reg(t, on_reg + 3'd1, 16'(addr));
        write_reg(t, on_reg + 3'd2, 16'(num));
        write_reg(t, on_reg, 16'd1);
    endtask

    task automatic stream_words();
        int max_len;
        logic [glb_pkg::DATA_WIDTH-1:0] word;
        max_len = 0;
        for (int t = 0; t < glb_pkg::NUM_TILES; t++) begin
            if (strm_len[t] > max_len) max_len = strm_len[t];
        end
        // Shorter streams go idle while longer ones finish
        for (int k = 0; k < max_len; k++) begin
            for (int t = 0; t < glb_pkg::NUM_TILES; t++) begin
                word = 16'($urandom());
                strm_f2g[t].valid = (k < strm_len[t]);
                strm_f2g[t].data = word;
                if (k < strm_len[t]) record_store(t, word);
            end
            step();
        end
        for (int t = 0; t < glb_pkg::NUM_TILES; t++) strm_f2g[t] = '0;
    endtask

    task automatic start_loads(input logic [glb_pkg::NUM_TILES-1:0] mask);
        strm_start_pulse = mask;
        for (int t = 0; t < glb_pkg::NUM_TILES; t++) begin
            if (mask[t]) queue_load(t);
        end
        step();
        strm_start_pulse = '0;
    endtask

    // Wait for all expected beats and done pulses
    task automatic wait_idle();
        while (!all_done()) step();
    endtask

    initial begin
        void'($urandom(4070));
        reset = 1'b1;
        cfg = '0;
        strm_start_pulse = '0;
        for (int t = 0; t < glb_pkg::NUM_TILES; t++) begin
            strm_f2g[t] = '0;
            model_cfg[t] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        // Random stores on all tiles with odd tiles streaming twice
        for (int t = 0; t < glb_pkg::NUM_TILES; t++) begin
            region_addr[t] = int'($urandom() % glb_pkg::BANK_WORDS);
            region_num[t] = 16 + int'($urandom() % 49);
            set_region(t, glb_pkg::REG_STORE_ON, region_addr[t], region_num[t]);
            strm_len[t] = region_num[t] * (1 + t % 2);
        end
        stream_words();
        wait_idle();

        // Readback from all tiles in the same cycle
        for (int t = 0; t < glb_pkg::NUM_TILES; t++) begin
            set_region(t, glb_pkg::REG_LOAD_ON, region_addr[t], region_num[t]);
        end
        start_loads('1);
        wait_idle();

        // Beats with stores off are dropped
        for (int t = 0; t < glb_pkg::NUM_TILES; t++) begin
            write_reg(t, glb_pkg::REG_STORE_ON, 16'd0);
            strm_len[t] = 32;
        end
        stream_words();
        start_loads('1);
        wait_idle();

        // Start with load off and a second start mid-load
        write_reg(1, glb_pkg::REG_LOAD_ON, 16'd0);
        start_loads(tile_mask(1));
        write_reg(1, glb_pkg::REG_LOAD_ON, 16'd1);
        start_loads(tile_mask(1));
        repeat (3) step();
        start_loads(tile_mask(1));
        wait_idle();

        // New regions on tile 2 only
        region_addr[2] = int'($urandom() % glb_pkg::BANK_WORDS);
        region_num[2] = 16 + int'($urandom() % 49);
        set_region(2, glb_pkg::REG_STORE_ON, region_addr[2], region_num[2]);
        set_region(2, glb_pkg::REG_LOAD_ON, region_addr[2], region_num[2]);
        for (int t = 0; t < glb_pkg::NUM_TILES; t++) strm_len[t] = 24;
        strm_len[2] = region_num[2];
        stream_words();
        wait_idle();
        start_loads('1);
        wait_idle();

        // Region across the bank end streamed twice
        set_region(0, glb_pkg::REG_STORE_ON, 250, 12);
        set_region(0, glb_pkg::REG_LOAD_ON, 250, 12);
        for (int t = 0; t < glb_pkg::NUM_TILES; t++) strm_len[t] = 0;
        strm_len[0] = 12;
        stream_words();
        wait_idle();
        stream_words();
        wait_idle();
        start_loads(tile_mask(0));
        wait_idle();
        // Wrapped words sit at the bank start
        write_reg(0, glb_pkg::REG_LOAD_ADDR, 16'd0);
        write_reg(0, glb_pkg::REG_LOAD_NUM, 16'd6);
        start_loads(tile_mask(0));
        wait_idle();

        // Room for stray beats or pulses
        repeat (4*glb_pkg::NUM_TILES) step();
        for (int t = 0; t < glb_pkg::NUM_TILES; t++) begin
            if (exp_q[t].size() != 0) begin
                $display("Tile %0d never sent %0d expected load beats", t, exp_q[t].size());
                other_errors++;
            end
        end
        for (int b = 0; b < 2*glb_pkg::NUM_TILES; b++) begin
            if (int_seen[b] < int_exp[b]) begin
                $display("Interrupt bit %0d is missing pulses, saw %0d of %0d",
                         b, int_seen[b], int_exp[b]);
                other_errors++;
            end
        end
        $display("Errors: data %0d, interrupt %0d, other %0d",
                 data_errors, int_errors, other_errors);
        if (data_errors + int_errors + other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
src/glb_pkg.sv
src/glb_tile_cfg.sv
src/glb_core.sv
src/glb_tile.sv
src/glb_top.sv
verification/glb_tb.sv

// File: Makefile
# Verilator build and run of the buffer tile testbench

VERILATOR ?= verilator
TOP       ?= glb_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# Fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(BUILD_DIR)
